// ==== fetch_frontend.f ====
fetch_pkg.sv
cache_mem.sv
icache_ctrl.sv
fetch_unit.sv
fetch_buffer.sv
dmem_port.sv
mem_arbiter.sv
fetch_frontend.sv
mem_model_tb.sv
fetch_frontend_tb.sv

// ==== fetch_frontend_tb.sv ====
`timescale 1ns/1ps

module fetch_frontend_tb import fetch_pkg::*; ();

  localparam logic [31:0] SEED = 32'h4777d1f8;
  localparam int TRANSACTIONS    = 40 + 4 * 12 + 40 + 20 + 16 + 12;
  localparam int WATCHDOG_CYCLES = TRANSACTIONS * 400;

  logic       clock;
  logic       rst;
  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp;
  redirect_t  redirect;
  logic       fetch_valid;
  fetch_pkt_t fetch_pkt;
  logic       fetch_ready;
  logic       load_req_valid;
  load_req_t  load_req;
  logic       load_req_ready;
  logic       load_rsp_valid;
  load_rsp_t  load_rsp;
  logic       load_rsp_ready;

  // reference model state
  logic [MEM_ADDR_BITS-1:0] exp_pc;
  logic                     exp_skip;
  logic [63:0]              load_q [$];
  int                       pkts_seen;
  int                       pkts_want;
  int                       loads_sent;
  int                       loads_done;
  int                       loads_want;
  logic                     rand_ready;
  logic                     quiet_bus;
  logic                     held;
  fetch_pkt_t               held_pkt;
  logic [31:0]              drive_rnd;
  logic [31:0]              plan_rnd;

  fetch_frontend u_fetch_frontend (
    .clock, .rst, .mem_req, .mem_rsp, .redirect, .fetch_valid, .fetch_pkt, .fetch_ready,
    .load_req_valid, .load_req, .load_req_ready, .load_rsp_valid, .load_rsp, .load_rsp_ready
  );

  mem_model_tb #(.SEED(SEED)) u_mem_model (.clock, .rst, .mem_req, .mem_rsp);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  ////////////////////////////////////////
  // helpers and compare tasks
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // memory contents at a block address
  function automatic logic [63:0] block_word(input logic [MEM_ADDR_BITS-1:0] a);
    return (64'(a) << 32) ^ 64'h5a5a_0000_0000_a5a5;
  endfunction

  function automatic fetch_pkt_t expected_pkt(input logic [MEM_ADDR_BITS-1:0] pc,
                                              input logic skip);
    fetch_pkt_t p;
    logic [63:0] w;
    w = block_word(pc);
    p.pc         = pc;
    p.inst[0]    = w[31:0];
    p.inst[1]    = w[63:32];
    p.slot_valid = {1'b1, !skip};
    return p;
  endfunction

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_fetch(input fetch_pkt_t got, input fetch_pkt_t exp);
    if (got !== exp) stop_with_error($sformatf("Fail fetch_pkt got %h expected %h", got, exp));
  endtask

  task automatic check_load(input load_rsp_t got, input load_rsp_t exp);
    if (got !== exp) stop_with_error($sformatf("Fail load_rsp got %h expected %h", got, exp));
  endtask

  task automatic check_cmd(input mem_cmd_t got, input mem_cmd_t exp);
    if (got !== exp) stop_with_error($sformatf("Fail mem_req.cmd got %h expected %h", got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) stop_with_error($sformatf("Fail %s got %h expected %h", name, got, exp));
  endtask

  task automatic fetch_blocks(input int n);
    @(negedge clock);
    pkts_want = pkts_seen + n;
    while (pkts_seen < pkts_want) @(negedge clock);
  endtask

  // one-cycle redirect pulse
  task automatic redirect_to(input logic [MEM_ADDR_BITS-1:0] target);
    @(posedge clock);
    redirect <= {1'b1, target};
    @(posedge clock);
    redirect <= '0;
  endtask

  task automatic wait_bus_idle(input int n);
    int quiet;
    quiet = 0;
    while (quiet < n) begin
      @(negedge clock);
      quiet = (mem_req.cmd == bus_none) ? quiet + 1 : 0;
    end
  endtask

  ////////////////////////////////////////
  // per-cycle checks and stimulus
  ////////////////////////////////////////

  always @(posedge clock) begin : drive_and_check
    logic [31:0] r;
    load_rsp_t   exp_rsp;
    if (!rst) begin
      drive_rnd = xorshift(drive_rnd);
      r = drive_rnd;
      // a waiting packet must not change
      if (held) begin
        check_flag(fetch_valid, 1'b1, "fetch_valid");
        check_fetch(fetch_pkt, held_pkt);
      end
      held     = fetch_valid && !fetch_ready && !redirect.valid;
      held_pkt = fetch_pkt;
      if (fetch_valid && fetch_ready) begin
        check_fetch(fetch_pkt, expected_pkt(exp_pc, exp_skip));
        exp_pc    = exp_pc + MEM_ADDR_BITS'(8);
        exp_skip  = 1'b0;
        pkts_seen = pkts_seen + 1;
      end
      if (redirect.valid) begin
        exp_pc   = {redirect.target[MEM_ADDR_BITS-1:BLOCK_OFFSET_BITS], 3'b000};
        exp_skip = redirect.target[2];
      end
      if (quiet_bus && mem_req.cmd != bus_none) begin
        stop_with_error("a bus command appeared while fetch stayed inside a cached range");
      end
      if (load_req_valid && load_req_ready) begin
        load_q.push_back(block_word({load_req.addr[MEM_ADDR_BITS-1:3], 3'b000}));
        loads_sent = loads_sent + 1;
      end
      if (load_rsp_valid && load_rsp_ready) begin
        if (load_q.size() == 0) stop_with_error("a load response came with no load pending");
        exp_rsp.data = load_q.pop_front();
        check_load(load_rsp, exp_rsp);
        loads_done = loads_done + 1;
      end
      fetch_ready    <= (pkts_seen < pkts_want) && (!rand_ready || r[1:0] != 2'b00);
      load_rsp_ready <= r[2] || r[3];
      if (!load_req_valid || load_req_ready) begin
        load_req_valid <= (loads_sent < loads_want) && r[4];
        load_req       <= r[31:16];
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    stop_with_error("watchdog expired, the run hung waiting for the DUT");
  end

  initial begin : main
    logic [MEM_ADDR_BITS-1:0] target;
    rst            = 1'b1;
    redirect       = '0;
    fetch_ready    = 1'b0;
    load_req_valid = 1'b0;
    load_req       = '0;
    load_rsp_ready = 1'b0;
    exp_pc         = '0;
    exp_skip       = 1'b0;
    pkts_seen      = 0;
    pkts_want      = 0;
    loads_sent     = 0;
    loads_done     = 0;
    loads_want     = 0;
    rand_ready     = 1'b0;
    quiet_bus      = 1'b0;
    held           = 1'b0;
    drive_rnd      = SEED;
    plan_rnd       = ~SEED;
    repeat (16) @(posedge clock);
    rst <= 1'b0;
    // idle outputs straight out of reset
    @(negedge clock);
    check_cmd(mem_req.cmd, bus_none);
    check_flag(fetch_valid, 1'b0, "fetch_valid");
    check_flag(load_rsp_valid, 1'b0, "load_rsp_valid");
    fetch_blocks(40);
    // random redirects under back-pressure
    rand_ready = 1'b1;
    repeat (4) begin
      plan_rnd = xorshift(plan_rnd);
      target   = plan_rnd[15:0] & 16'hfffc;
      redirect_to(target);
      fetch_blocks(12);
    end
    // loads competing with fetch misses
    loads_want = 20;
    plan_rnd   = xorshift(plan_rnd);
    redirect_to(plan_rnd[15:0] & 16'hfffc);
    fetch_blocks(40);
    while (loads_done < loads_want || load_rsp_valid) @(negedge clock);
    // second pass over a range that is still cached
    plan_rnd = xorshift(plan_rnd);
    target   = {plan_rnd[15:3], 3'b000};
    redirect_to(target);
    fetch_blocks(16);
    wait_bus_idle(24);
    quiet_bus = 1'b1;
    redirect_to(target);
    fetch_blocks(12);
    quiet_bus = 1'b0;
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== mem_model_tb.sv ====
`timescale 1ns/1ps

module mem_model_tb import fetch_pkg::*; #(
  parameter logic [31:0] SEED = 32'h4777d1f8
) (
  input  logic     clock,
  input  logic     rst,
  input  mem_req_t mem_req,
  output mem_rsp_t mem_rsp
);

  logic [31:0]              rnd;
  logic                     accept;
  mem_tag_t                 next_tag;
  mem_tag_t                 response;
  logic [15:0]              pend_valid;
  logic [MEM_ADDR_BITS-1:0] pend_addr [16];
  logic [2:0]               pend_wait [16];
  mem_tag_t                 ret_tag;
  logic [63:0]              ret_data;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [63:0] block_word(input logic [MEM_ADDR_BITS-1:0] a);
    return (64'(a) << 32) ^ 64'h5a5a_0000_0000_a5a5;
  endfunction

  // accept decided one cycle ahead, tag answer is combinational
  assign response = (mem_req.cmd != bus_none && accept) ? next_tag : '0;
  assign mem_rsp  = {response, ret_tag, ret_data};

  always @(posedge clock) begin : model
    int sel;
    if (rst) begin
      rnd = SEED;
      accept     <= 1'b0;
      next_tag   <= 4'd1;
      pend_valid <= '0;
      ret_tag    <= '0;
      ret_data   <= '0;
    end else begin
      rnd = xorshift(rnd);
      // refuse about one command in four
      accept <= (rnd[1:0] != 2'd0);
      // one return per cycle, lowest ready tag first
      sel = 0;
      for (int t = 15; t >= 1; t--) begin
        if (pend_valid[t] && pend_wait[t] == 3'd0) sel = t;
      end
      ret_tag <= '0;
      if (sel != 0) begin
        ret_tag         <= mem_tag_t'(sel);
        ret_data        <= block_word(pend_addr[sel]);
        pend_valid[sel] <= 1'b0;
      end
      for (int t = 1; t < 16; t++) begin
        if (pend_valid[t] && pend_wait[t] != 3'd0) pend_wait[t] <= pend_wait[t] - 1'b1;
      end
      if (response != '0) begin
        pend_valid[next_tag] <= 1'b1;
        pend_addr[next_tag]  <= mem_req.addr;
        pend_wait[next_tag]  <= rnd[6:4];
        next_tag             <= (next_tag == 4'd15) ? 4'd1 : next_tag + 1'b1;
      end
    end
  end

endmodule

// ==== fetch_frontend.sv ====
`timescale 1ns/1ps

module fetch_frontend import fetch_pkg::*; #(
  parameter int CACHE_LINES = 32,
  parameter int FB_DEPTH    = 8
) (
  input  logic       clock,
  input  logic       rst,
  output mem_req_t   mem_req,
  input  mem_rsp_t   mem_rsp,
  input  redirect_t  redirect,
  output logic       fetch_valid,
  output fetch_pkt_t fetch_pkt,
  input  logic       fetch_ready,
  input  logic       load_req_valid,
  input  load_req_t  load_req,
  output logic       load_req_ready,
  output logic       load_rsp_valid,
  output load_rsp_t  load_rsp,
  input  logic       load_rsp_ready
);

  mem_req_t                 imem_req;
  mem_req_t                 dmem_req;
  mem_tag_t                 imem_rsp_tag;
  mem_tag_t                 dmem_rsp_tag;
  logic [MEM_ADDR_BITS-1:0] fetch_addr;
  logic                     hit;
  logic [63:0]              hit_data;
  logic                     buf_full;
  logic                     push;
  fetch_pkt_t               push_pkt;

  ////////////////////////////////////////
  // instruction path
  ////////////////////////////////////////

  icache_ctrl #(.CACHE_LINES(CACHE_LINES)) u_icache_ctrl (
    .clock     (clock),
    .rst       (rst),
    .fetch_addr(fetch_addr),
    .hit       (hit),
    .hit_data  (hit_data),
    .mem_req   (imem_req),
    .rsp_tag   (imem_rsp_tag),
    .mem_rsp   (mem_rsp)
  );

  fetch_unit u_fetch_unit (
    .clock     (clock),
    .rst       (rst),
    .redirect  (redirect),
    .hit       (hit),
    .hit_data  (hit_data),
    .buf_full  (buf_full),
    .fetch_addr(fetch_addr),
    .push      (push),
    .push_pkt  (push_pkt)
  );

  // redirect empties the queue at the same edge the pc moves
  fetch_buffer #(.FB_DEPTH(FB_DEPTH)) u_fetch_buffer (
    .clock    (clock),
    .rst      (rst),
    .flush    (redirect.valid),
    .push     (push),
    .push_pkt (push_pkt),
    .full     (buf_full),
    .out_valid(fetch_valid),
    .out_pkt  (fetch_pkt),
    .out_ready(fetch_ready)
  );

  ////////////////////////////////////////
  // data path and bus sharing
  ////////////////////////////////////////

  dmem_port u_dmem_port (
    .clock    (clock),
    .rst      (rst),
    .req_valid(load_req_valid),
    .req      (load_req),
    .req_ready(load_req_ready),
    .rsp_valid(load_rsp_valid),
    .rsp      (load_rsp),
    .rsp_ready(load_rsp_ready),
    .mem_req  (dmem_req),
    .rsp_tag  (dmem_rsp_tag),
    .mem_rsp  (mem_rsp)
  );

  mem_arbiter u_mem_arbiter (
    .imem_req    (imem_req),
    .dmem_req    (dmem_req),
    .bus_req     (mem_req),
    .bus_rsp_tag (mem_rsp.response),
    .imem_rsp_tag(imem_rsp_tag),
    .dmem_rsp_tag(dmem_rsp_tag)
  );

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter import fetch_pkg::*; (
  input  mem_req_t imem_req,
  input  mem_req_t dmem_req,
  output mem_req_t bus_req,
  input  mem_tag_t bus_rsp_tag,
  output mem_tag_t imem_rsp_tag,
  output mem_tag_t dmem_rsp_tag
);

  logic dmem_sel;

  // data side wins whenever it asks
  assign dmem_sel = (dmem_req.cmd != bus_none);

  assign bus_req = dmem_sel ? dmem_req : imem_req;

  // the client not chosen sees a refusal and retries
  assign imem_rsp_tag = dmem_sel ? '0 : bus_rsp_tag;
  assign dmem_rsp_tag = dmem_sel ? bus_rsp_tag : '0;

endmodule

// ==== dmem_port.sv ====
`timescale 1ns/1ps

module dmem_port import fetch_pkg::*; (
  input  logic      clock,
  input  logic      rst,
  input  logic      req_valid,
  input  load_req_t req,
  output logic      req_ready,
  output logic      rsp_valid,
  output load_rsp_t rsp,
  input  logic      rsp_ready,
  output mem_req_t  mem_req,
  input  mem_tag_t  rsp_tag,
  input  mem_rsp_t  mem_rsp
);

  typedef enum logic [1:0] {
    st_idle,
    st_accept,
    st_data
  } state_t;

  state_t                   state;
  logic [MEM_ADDR_BITS-1:0] load_addr;
  mem_tag_t                 load_tag;
  logic                     data_done;

  // one load in flight, so no new request until the old response is gone
  assign req_ready = (state == st_idle) && !rsp_valid;
  assign data_done = (state == st_data) && (mem_rsp.tag == load_tag);

  always_comb begin
    mem_req.cmd  = (state == st_accept) ? bus_load : bus_none;
    mem_req.addr = {load_addr[MEM_ADDR_BITS-1:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state     <= st_idle;
      rsp_valid <= 1'b0;
    end else begin
      case (state)
        st_idle:   if (req_valid && req_ready) state <= st_accept;
        st_accept: if (rsp_tag != '0) state <= st_data;
        st_data:   if (data_done) state <= st_idle;
        default:   state <= st_idle;
      endcase
      if (data_done) begin
        rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid && req_ready) load_addr <= req.addr;
    if (state == st_accept && rsp_tag != '0) load_tag <= rsp_tag;
    if (data_done) rsp.data <= mem_rsp.data;
  end

  // response held under back-pressure
  a_rsp_stable: assert property (@(posedge clock) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

// ==== fetch_buffer.sv ====
`timescale 1ns/1ps

module fetch_buffer import fetch_pkg::*; #(
  parameter int FB_DEPTH = 8
) (
  input  logic       clock,
  input  logic       rst,
  input  logic       flush,
  input  logic       push,
  input  fetch_pkt_t push_pkt,
  output logic       full,
  output logic       out_valid,
  output fetch_pkt_t out_pkt,
  input  logic       out_ready
);

  localparam int PTR_BITS = $clog2(FB_DEPTH);
  localparam int CNT_BITS = $clog2(FB_DEPTH + 1);

  fetch_pkt_t          entries [FB_DEPTH];
  logic [PTR_BITS-1:0] head;
  logic [PTR_BITS-1:0] tail;
  logic [CNT_BITS-1:0] count;
  logic                pop;

  // wrap for any depth, not just powers of two
  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] p);
    next_ptr = (p == PTR_BITS'(FB_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full      = (count == CNT_BITS'(FB_DEPTH));
  assign out_valid = (count != '0);
  assign out_pkt   = entries[head];
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clock) begin
    if (push) begin
      entries[tail] <= push_pkt;
    end
  end

  ////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (rst || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) tail <= next_ptr(tail);
      if (pop) head <= next_ptr(head);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // fetch_unit must stall on full
  a_no_overflow: assert property (@(posedge clock) disable iff (rst) !(push && full));

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; (
  input  logic                     clock,
  input  logic                     rst,
  input  redirect_t                redirect,
  input  logic                     hit,
  input  logic [63:0]              hit_data,
  input  logic                     buf_full,
  output logic [MEM_ADDR_BITS-1:0] fetch_addr,
  output logic                     push,
  output fetch_pkt_t               push_pkt
);

  logic [MEM_ADDR_BITS-1:0] pc;
  // redirect landed on the second word of the block
  logic                     skip_slot0;

  assign fetch_addr = pc;

  // a hit in the redirect cycle belongs to the old path
  assign push = hit && !buf_full && !redirect.valid;

  always_comb begin
    push_pkt.pc         = pc;
    push_pkt.inst[0]    = hit_data[31:0];
    push_pkt.inst[1]    = hit_data[63:32];
    push_pkt.slot_valid = {1'b1, !skip_slot0};
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      pc         <= '0;
      skip_slot0 <= 1'b0;
    end else if (redirect.valid) begin
      pc         <= {redirect.target[MEM_ADDR_BITS-1:BLOCK_OFFSET_BITS],
                     {BLOCK_OFFSET_BITS{1'b0}}};
      skip_slot0 <= redirect.target[BLOCK_OFFSET_BITS-1];
    end else if (push) begin
      pc         <= pc + MEM_ADDR_BITS'(8);
      skip_slot0 <= 1'b0;
    end
  end

endmodule

// ==== icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl import fetch_pkg::*; #(
  parameter int CACHE_LINES = 32
) (
  input  logic                     clock,
  input  logic                     rst,
  input  logic [MEM_ADDR_BITS-1:0] fetch_addr,
  output logic                     hit,
  output logic [63:0]              hit_data,
  output mem_req_t                 mem_req,
  input  mem_tag_t                 rsp_tag,
  input  mem_rsp_t                 mem_rsp
);

  localparam int IDX_BITS = $clog2(CACHE_LINES);
  localparam int TAG_BITS = MEM_ADDR_BITS - BLOCK_OFFSET_BITS - IDX_BITS;

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait
  } state_t;

  state_t              state;
  logic [IDX_BITS-1:0] cur_idx;
  logic [TAG_BITS-1:0] cur_tag;
  logic [IDX_BITS-1:0] miss_idx;
  logic [TAG_BITS-1:0] miss_tag;
  mem_tag_t            miss_mem_tag;
  logic                fill;

  assign cur_idx = fetch_addr[BLOCK_OFFSET_BITS +: IDX_BITS];
  assign cur_tag = fetch_addr[MEM_ADDR_BITS-1 -: TAG_BITS];

  // outstanding block is written even after a redirect
  assign fill = (state == st_wait) && (mem_rsp.tag == miss_mem_tag);

  cache_mem #(
    .CACHE_LINES(CACHE_LINES)
  ) u_cache_mem (
    .clock  (clock),
    .rst    (rst),
    .rd_idx (cur_idx),
    .rd_tag (cur_tag),
    .rd_data(hit_data),
    .rd_hit (hit),
    .wr_en  (fill),
    .wr_idx (miss_idx),
    .wr_tag (miss_tag),
    .wr_data(mem_rsp.data)
  );

  always_comb begin
    mem_req.cmd  = (state == st_request) ? bus_load : bus_none;
    mem_req.addr = {miss_tag, miss_idx, {BLOCK_OFFSET_BITS{1'b0}}};
  end

  ////////////////////////////////////////
  // miss sequencer
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:    if (!hit) state <= st_request;
        st_request: if (rsp_tag != '0) state <= st_wait;
        st_wait:    if (fill) state <= st_idle;
        default:    state <= st_idle;
      endcase
    end
  end

  // block address and accepted tag of the pending miss
  always_ff @(posedge clock) begin
    if (state == st_idle && !hit) begin
      miss_idx <= cur_idx;
      miss_tag <= cur_tag;
    end
    if (state == st_request && rsp_tag != '0) begin
      miss_mem_tag <= rsp_tag;
    end
  end

  // refused request keeps its command and block address
  a_req_held: assert property (@(posedge clock) disable iff (rst)
    mem_req.cmd != bus_none && rsp_tag == '0 |=> $stable(mem_req));

endmodule

// ==== cache_mem.sv ====
`timescale 1ns/1ps

module cache_mem import fetch_pkg::*; #(
  parameter int CACHE_LINES = 32
) (
  input  logic                                                          clock,
  input  logic                                                          rst,
  input  logic [$clog2(CACHE_LINES)-1:0]                                rd_idx,
  input  logic [MEM_ADDR_BITS-BLOCK_OFFSET_BITS-$clog2(CACHE_LINES)-1:0] rd_tag,
  output logic [63:0]                                                   rd_data,
  output logic                                                          rd_hit,
  input  logic                                                          wr_en,
  input  logic [$clog2(CACHE_LINES)-1:0]                                wr_idx,
  input  logic [MEM_ADDR_BITS-BLOCK_OFFSET_BITS-$clog2(CACHE_LINES)-1:0] wr_tag,
  input  logic [63:0]                                                   wr_data
);

  localparam int TAG_BITS = MEM_ADDR_BITS - BLOCK_OFFSET_BITS - $clog2(CACHE_LINES);

  logic [63:0]          data_array [CACHE_LINES];
  logic [TAG_BITS-1:0]  tag_array  [CACHE_LINES];
  logic [CACHE_LINES-1:0] valid;

  // combinational read port
  assign rd_data = data_array[rd_idx];
  assign rd_hit  = valid[rd_idx] && (tag_array[rd_idx] == rd_tag);

  always_ff @(posedge clock) begin
    if (rst) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      data_array[wr_idx] <= wr_data;
      tag_array[wr_idx]  <= wr_tag;
    end
  end

endmodule

// ==== fetch_pkg.sv ====
package fetch_pkg;

  ////////////////////////////////////////
  // address geometry
  ////////////////////////////////////////

  // only the low 16 address bits reach memory
  localparam int MEM_ADDR_BITS     = 16;
  // byte offset inside one 64-bit block
  localparam int BLOCK_OFFSET_BITS = 3;

  ////////////////////////////////////////
  // memory bus
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    bus_none  = 2'h0,
    bus_load  = 2'h1,
    bus_store = 2'h2
  } mem_cmd_t;

  // zero means no tag
  typedef logic [3:0] mem_tag_t;

  typedef struct packed {
    mem_cmd_t                 cmd;
    logic [MEM_ADDR_BITS-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    mem_tag_t    response;
    mem_tag_t    tag;
    logic [63:0] data;
  } mem_rsp_t;

  ////////////////////////////////////////
  // fetch and load ports
  ////////////////////////////////////////

  typedef struct packed {
    logic [MEM_ADDR_BITS-1:0] pc;
    logic [1:0][31:0]         inst;
    logic [1:0]               slot_valid;
  } fetch_pkt_t;

  typedef struct packed {
    logic                     valid;
    logic [MEM_ADDR_BITS-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic [MEM_ADDR_BITS-1:0] addr;
  } load_req_t;

  typedef struct packed {
    logic [63:0] data;
  } load_rsp_t;

endpackage
